/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := pma_tx_tb
FILELIST  := pma_tx.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* dv/pma_tx_chk.sv */
`default_nettype none

module pma_tx_chk (
  input logic                  clk,
  input logic                  arst_n,
  input pma_tx_pkg::axil_req_t axil_req,
  input pma_tx_pkg::axil_rsp_t axil_rsp,
  input logic                  word_valid,
  input pma_tx_pkg::word_t     word_data,
  input logic                  word_ready,
  input pma_tx_pkg::tx_ctrl_t  tx_ctrl,
  input pma_tx_pkg::line_out_t line_out
);

  timeunit 1ns;
  timeprecision 100ps;

  // a raised valid keeps its payload steady until the other side takes it
  aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
    axil_req.awvalid && !axil_rsp.awready |=> axil_req.awvalid && $stable(axil_req.awaddr))
    else $error("awvalid dropped or awaddr changed before awready");

  w_hold: assert property (@(posedge clk) disable iff (!arst_n)
    axil_req.wvalid && !axil_rsp.wready |=>
      axil_req.wvalid && $stable(axil_req.wdata) && $stable(axil_req.wstrb))
    else $error("wvalid dropped or wdata or wstrb changed before wready");

  ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
    axil_req.arvalid && !axil_rsp.arready |=> axil_req.arvalid && $stable(axil_req.araddr))
    else $error("arvalid dropped or araddr changed before arready");

  b_hold: assert property (@(posedge clk) disable iff (!arst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
    else $error("bvalid dropped before bready");

  r_hold: assert property (@(posedge clk) disable iff (!arst_n)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
    else $error("rvalid dropped or rdata changed before rready");

  word_hold: assert property (@(posedge clk) disable iff (!arst_n)
    word_valid && !word_ready |=> word_valid && $stable(word_data))
    else $error("word_valid dropped or word_data changed before word_ready");

  // the first bit of a word is never sent while the line is idle
  tick_not_idle: assert property (@(posedge clk) disable iff (!arst_n)
    !(line_out.word_tick && line_out.elecidle))
    else $error("word_tick and elecidle high together");

  lpbk_off: assert property (@(posedge clk) disable iff (!arst_n)
    !tx_ctrl.loopback_en |-> !line_out.seriallpbkout)
    else $error("seriallpbkout active with loopback off");

endmodule

bind pma_tx_top pma_tx_chk u_chk (
  .clk        (clk),
  .arst_n     (arst_n),
  .axil_req   (axil_req),
  .axil_rsp   (axil_rsp),
  .word_valid (word_valid),
  .word_data  (word_data),
  .word_ready (word_ready),
  .tx_ctrl    (tx_ctrl),
  .line_out   (line_out)
);

`default_nettype wire

/* dv/pma_tx_patterns.txt */
# write <addr> <data> <wstrb> | read <addr> <expected> | push <word> | stream <count>
# all numbers hex, stream waits for count words and checks them in push order
read 0 1
read 4 0
read 8 0
read c 0
write 0 d 0
read 0 1
write 0 6 1
read 0 6
write 4 ffff f
read 4 0
write 0 2 1
push 12345
push a5a5a
push fffff
push 00001
push 80000
push 3c3c3
stream 6
read 4 6
write 0 8 1
push 5a5a5
push 0f0f0
stream 2
write 0 c 1
push 96969
push 69696
stream 2
write 0 1 1
push 11111
push 22222
push 33333
push 44444
stream 0
write 0 0 1
stream 4
read 4 e

/* dv/pma_tx_tb.sv */
`default_nettype none

module pma_tx_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import pma_tx_pkg::*;

  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned RAND_SEED  = 32'h5dbfba2a;

  logic      clk;
  logic      arst_n;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  logic      word_valid;
  word_t     word_data;
  logic      word_ready;
  line_out_t line_out;

  // expected CTRL contents: bit 0 force, bit 1 loopback, bits 3:2 divide code
  logic [3:0]  ctrl_model;
  word_t       pushed_q[$];
  word_t       recv_q[$];
  logic        joined_q[$];
  string       cmd_q[$];
  logic [31:0] arg0_q[$];
  logic [31:0] arg1_q[$];
  logic [31:0] arg2_q[$];
  string       test_name;
  int unsigned cycles;
  int unsigned cycle_limit;

  always #4 clk = ~clk;

  pma_tx_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .word_valid (word_valid),
    .word_data  (word_data),
    .word_ready (word_ready),
    .line_out   (line_out)
  );

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                         test_name, what, expected, actual));
    end
  endtask

  task automatic read_patterns();
    int          fd;
    int          rc;
    int          n_push;
    string       cmd;
    string       rest;
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] a2;
    n_push = 0;
    fd = $fopen("dv/pma_tx_patterns.txt", "r");
    if (fd == 0) begin
      fail_run("cannot open the pattern file dv/pma_tx_patterns.txt");
    end
    while (!$feof(fd)) begin
      rc = $fscanf(fd, "%s", cmd);
      if (rc == 1) begin
        a0 = '0;
        a1 = '0;
        a2 = '0;
        case (cmd)
          "#":              rc = $fgets(rest, fd);
          "write":          rc = $fscanf(fd, "%h %h %h", a0, a1, a2);
          "read":           rc = $fscanf(fd, "%h %h", a0, a1);
          "push", "stream": rc = $fscanf(fd, "%h", a0);
          default:          fail_run({"unknown command in pattern file: ", cmd});
        endcase
        if (cmd != "#") begin
          cmd_q.push_back(cmd);
          arg0_q.push_back(a0);
          arg1_q.push_back(a1);
          arg2_q.push_back(a2);
          if (cmd == "push") begin
            n_push++;
          end
        end
      end
    end
    $fclose(fd);
    cycle_limit = 200 * cmd_q.size() + n_push * WORD_W * 8 * 2;
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] strb);
    axil_req.awaddr  = addr[3:0];
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb[3:0];
    axil_req.wvalid  = 1'b1;
    axil_req.bready  = 1'b1;
    while (axil_rsp.awready !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    // both write channels are taken in the same cycle
    check_value("wready", 32'd1, 32'(axil_rsp.wready));
    @(posedge clk);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    while (axil_rsp.bvalid !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    check_value("bresp", 32'd0, 32'(axil_rsp.bresp));
    // only byte lane 0 at the CTRL address changes the register
    if (addr[3:0] == 4'h0 && strb[0]) begin
      ctrl_model = data[3:0];
    end
    @(posedge clk);
    #1;
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, input logic [31:0] expected);
    axil_req.araddr  = addr[3:0];
    axil_req.arvalid = 1'b1;
    axil_req.rready  = 1'b1;
    while (axil_rsp.arready !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    axil_req.arvalid = 1'b0;
    while (axil_rsp.rvalid !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    check_value("rdata", expected, axil_rsp.rdata);
    check_value("rresp", 32'd0, 32'(axil_rsp.rresp));
    @(posedge clk);
    #1;
    axil_req.rready = 1'b0;
  endtask

  task automatic push_word(input logic [31:0] data);
    int unsigned gap;
    int          held;
    gap = $urandom() % 4;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    word_valid = 1'b1;
    word_data  = data[WORD_W-1:0];
    while (word_ready !== 1'b1) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    word_valid = 1'b0;
    pushed_q.push_back(data[WORD_W-1:0]);
    // with the line held idle nothing drains, so ready drops once the buffer is full
    if (ctrl_model[0]) begin
      held = pushed_q.size() - recv_q.size();
      check_value("word_ready", 32'(held < int'(FIFO_DEPTH)), 32'(word_ready));
    end
  endtask

  task automatic expect_stream(input int n);
    word_t exp_word;
    word_t got_word;
    logic  joined;
    if (n == 0) begin
      check_value("words sent while held", 32'd0, 32'(recv_q.size()));
      check_value("elecidle while held", 32'd1, 32'(line_out.elecidle));
    end else begin
      while (recv_q.size() < n) begin
        @(posedge clk);
        #1;
      end
      for (int i = 0; i < n; i++) begin
        exp_word = pushed_q.pop_front();
        got_word = recv_q.pop_front();
        joined   = joined_q.pop_front();
        check_value($sformatf("word %0d", i), 32'(exp_word), 32'(got_word));
        if (i > 0) begin
          check_value($sformatf("no gap before word %0d", i), 32'd1, 32'(joined));
        end
      end
      // with the buffer drained the line falls back to electrical idle
      if (pushed_q.size() == 0) begin
        check_value("elecidle after stream", 32'd1, 32'(line_out.elecidle));
        check_value("dataout after stream", 32'd0, 32'(line_out.dataout));
      end
    end
  endtask

  // samples every cycle of every bit period, starting at the word_tick cycle
  task automatic capture_word(output word_t w);
    int unsigned period;
    period = 32'd1 << ctrl_model[3:2];
    w = '0;
    for (int unsigned k = 0; k < WORD_W; k++) begin
      for (int unsigned c = 0; c < period; c++) begin
        if (c == 0) begin
          w[k] = line_out.dataout;
        end else begin
          check_value($sformatf("bit %0d held", k), 32'(w[k]), 32'(line_out.dataout));
        end
        check_value("elecidle during word", 32'd0, 32'(line_out.elecidle));
        @(negedge clk);
      end
    end
  endtask

  always begin : capture
    word_t w;
    logic  joined;
    @(negedge clk);
    joined = 1'b0;
    // a word_tick right where the last word ended means the words are back to back
    while (line_out.word_tick === 1'b1) begin
      capture_word(w);
      recv_q.push_back(w);
      joined_q.push_back(joined);
      joined = 1'b1;
    end
  end

  always @(negedge clk) begin
    if (arst_n) begin
      check_value("seriallpbkout", ctrl_model[1] ? 32'(line_out.dataout) : 32'd0,
                  32'(line_out.seriallpbkout));
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      fail_run($sformatf("timeout, the run did not finish within %0d cycles", cycle_limit));
    end
  end

  initial begin : main
    int unsigned seed_val;
    clk        = 1'b0;
    arst_n     = 1'b0;
    axil_req   = '0;
    word_valid = 1'b0;
    word_data  = '0;
    ctrl_model = 4'h1;
    cycles     = 0;
    test_name  = "setup";
    seed_val   = $urandom(RAND_SEED);
    read_patterns();
    repeat (4) @(posedge clk);
    #1;
    arst_n = 1'b1;
    test_name = "reset";
    check_value("dataout", 32'd0, 32'(line_out.dataout));
    check_value("elecidle", 32'd1, 32'(line_out.elecidle));
    check_value("word_tick", 32'd0, 32'(line_out.word_tick));
    check_value("seriallpbkout", 32'd0, 32'(line_out.seriallpbkout));
    check_value("word_ready", 32'd1, 32'(word_ready));
    check_value("bvalid", 32'd0, 32'(axil_rsp.bvalid));
    check_value("rvalid", 32'd0, 32'(axil_rsp.rvalid));
    for (int i = 0; i < cmd_q.size(); i++) begin
      test_name = $sformatf("command %0d %s", i, cmd_q[i]);
      case (cmd_q[i])
        "write": axil_write(arg0_q[i], arg1_q[i], arg2_q[i]);
        "read":  axil_read(arg0_q[i], arg1_q[i]);
        "push":  push_word(arg0_q[i]);
        default: expect_stream(int'(arg0_q[i]));
      endcase
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* pma_tx.f */
rtl/pma_tx_pkg.sv
rtl/pma_tx_csr.sv
rtl/pma_tx_rate_gen.sv
rtl/pma_tx_word_fifo.sv
rtl/pma_tx_serializer.sv
rtl/pma_tx_top.sv
dv/pma_tx_chk.sv
dv/pma_tx_tb.sv

/* rtl/pma_tx_csr.sv */
`default_nettype none

module pma_tx_csr (
  input  logic                  clk,
  input  logic                  arst_n,
  input  pma_tx_pkg::axil_req_t axil_req,
  output pma_tx_pkg::axil_rsp_t axil_rsp,
  input  logic                  word_done,
  output pma_tx_pkg::tx_ctrl_t  tx_ctrl
);

  import pma_tx_pkg::*;

  logic       wr_ack_q;
  logic       bvalid_q;
  logic       rd_ack_q;
  logic       rvalid_q;
  axil_data_t rdata_q;
  axil_data_t rd_mux;
  tx_ctrl_t   ctrl_q;
  sent_cnt_t  sent_cnt_q;

  // awready and wready rise together once both channels are valid.
  // No new write is taken while a response is still pending
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ack_q <= 1'b0;
      bvalid_q <= 1'b0;
    end else begin
      wr_ack_q <= axil_req.awvalid && axil_req.wvalid && !wr_ack_q && !bvalid_q;
      if (wr_ack_q) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
    end
  end

  // the write lands in the handshake cycle, only byte lane 0 carries CTRL
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q <= CTRL_RESET;
    end else if (wr_ack_q && (axil_req.awaddr == ADDR_CTRL) && axil_req.wstrb[0]) begin
      ctrl_q.elec_idle_force <= axil_req.wdata[CTRL_FORCE_BIT];
      ctrl_q.loopback_en     <= axil_req.wdata[CTRL_LPBK_BIT];
      ctrl_q.div_code        <= axil_req.wdata[CTRL_DIV_LSB +: 2];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sent_cnt_q <= '0;
    end else if (word_done) begin
      sent_cnt_q <= sent_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ack_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      rd_ack_q <= axil_req.arvalid && !rd_ack_q && !rvalid_q;
      if (rd_ack_q) begin
        rvalid_q <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // unmapped addresses read as zero
  always_comb begin
    rd_mux = '0;
    case (axil_req.araddr)
      ADDR_CTRL: begin
        rd_mux[CTRL_FORCE_BIT]     = ctrl_q.elec_idle_force;
        rd_mux[CTRL_LPBK_BIT]      = ctrl_q.loopback_en;
        rd_mux[CTRL_DIV_LSB +: 2]  = ctrl_q.div_code;
      end
      ADDR_STATUS: rd_mux[15:0] = sent_cnt_q;
      default:     rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rd_ack_q) begin
      rdata_q <= rd_mux;
    end
  end

  always_comb begin
    axil_rsp.awready = wr_ack_q;
    axil_rsp.wready  = wr_ack_q;
    axil_rsp.bresp   = RESP_OKAY;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.arready = rd_ack_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = RESP_OKAY;
    axil_rsp.rvalid  = rvalid_q;
  end

  assign tx_ctrl = ctrl_q;

endmodule

`default_nettype wire

/* rtl/pma_tx_pkg.sv */
`default_nettype none

package pma_tx_pkg;

  localparam int unsigned WORD_W         = 20;
  localparam int unsigned DEF_FIFO_DEPTH = 4;

  typedef logic [WORD_W-1:0] word_t;
  // bit period in clock cycles is 2**code
  typedef logic [1:0]        div_code_t;
  typedef logic [4:0]        bit_idx_t;
  typedef logic [3:0]        axil_addr_t;
  typedef logic [31:0]       axil_data_t;
  typedef logic [15:0]       sent_cnt_t;

  typedef struct packed {
    axil_addr_t awaddr;
    logic       awvalid;
    axil_data_t wdata;
    logic [3:0] wstrb;
    logic       wvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       arready;
    axil_data_t rdata;
    logic [1:0] rresp;
    logic       rvalid;
  } axil_rsp_t;

  typedef struct packed {
    logic      elec_idle_force;
    logic      loopback_en;
    div_code_t div_code;
  } tx_ctrl_t;

  typedef struct packed {
    logic dataout;
    logic elecidle;
    logic word_tick;
    logic seriallpbkout;
  } line_out_t;

  // the lane comes out of reset in forced electrical idle
  localparam tx_ctrl_t CTRL_RESET = '{elec_idle_force: 1'b1, loopback_en: 1'b0, div_code: 2'd0};

  localparam axil_addr_t ADDR_CTRL   = 4'h0;
  localparam axil_addr_t ADDR_STATUS = 4'h4;

  localparam int unsigned CTRL_FORCE_BIT = 0;
  localparam int unsigned CTRL_LPBK_BIT  = 1;
  localparam int unsigned CTRL_DIV_LSB   = 2;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef enum logic {
    IDLE,
    SHIFT
  } ser_state_e;

endpackage

`default_nettype wire

/* rtl/pma_tx_rate_gen.sv */
`default_nettype none

module pma_tx_rate_gen (
  input  logic                  clk,
  input  logic                  arst_n,
  input  pma_tx_pkg::div_code_t div_code,
  input  logic                  load,
  input  logic                  ser_idle,
  output logic                  bit_tick
);

  import pma_tx_pkg::*;

  div_code_t  code_q;
  div_code_t  code_d;
  logic [2:0] cnt_q;

  // the code is only picked up between words so a word never changes rate midway.
  // On a load the reload already uses the new code, so the first bit gets the new period
  assign code_d   = (load || ser_idle) ? div_code : code_q;
  assign bit_tick = (cnt_q == 3'd0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      code_q <= '0;
      cnt_q  <= '0;
    end else begin
      code_q <= code_d;
      if (bit_tick) begin
        cnt_q <= 3'((4'd1 << code_d) - 4'd1);
      end else begin
        cnt_q <= cnt_q - 3'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/pma_tx_serializer.sv */
`default_nettype none

module pma_tx_serializer (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  bit_tick,
  input  logic                  fifo_valid,
  input  pma_tx_pkg::word_t     fifo_data,
  output logic                  fifo_pop,
  input  pma_tx_pkg::tx_ctrl_t  tx_ctrl,
  output logic                  load,
  output logic                  ser_idle,
  output logic                  word_done,
  output pma_tx_pkg::line_out_t line_out
);

  import pma_tx_pkg::*;

  ser_state_e state_q;
  word_t      shreg_q;
  bit_idx_t   bit_idx_q;
  logic       last_bit;
  logic       dataout_q;
  logic       elecidle_q;
  logic       word_tick_q;

  assign last_bit = (bit_idx_q == bit_idx_t'(WORD_W - 1));

  // a new word starts only on a bit boundary, either from idle or right after
  // the last bit of the current word, which gives back-to-back words with no gap
  assign load      = bit_tick && fifo_valid && !tx_ctrl.elec_idle_force &&
                     ((state_q == IDLE) || last_bit);
  assign fifo_pop  = load;
  assign ser_idle  = (state_q == IDLE);
  assign word_done = (state_q == SHIFT) && bit_tick && last_bit;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q     <= IDLE;
      bit_idx_q   <= '0;
      dataout_q   <= 1'b0;
      elecidle_q  <= 1'b1;
      word_tick_q <= 1'b0;
    end else begin
      word_tick_q <= load;
      if (load) begin
        state_q    <= SHIFT;
        bit_idx_q  <= '0;
        dataout_q  <= fifo_data[0];
        elecidle_q <= 1'b0;
      end else if ((state_q == SHIFT) && bit_tick) begin
        if (last_bit) begin
          state_q    <= IDLE;
          dataout_q  <= 1'b0;
          elecidle_q <= 1'b1;
        end else begin
          bit_idx_q <= bit_idx_q + 1'b1;
          dataout_q <= shreg_q[0];
        end
      end
    end
  end

  // bit 0 goes straight to the line, so the register keeps the bits still to be sent
  always_ff @(posedge clk) begin
    if (load) begin
      shreg_q <= fifo_data >> 1;
    end else if ((state_q == SHIFT) && bit_tick) begin
      shreg_q <= shreg_q >> 1;
    end
  end

  always_comb begin
    line_out.dataout       = dataout_q;
    line_out.elecidle      = elecidle_q;
    line_out.word_tick     = word_tick_q;
    line_out.seriallpbkout = dataout_q & tx_ctrl.loopback_en;
  end

endmodule

`default_nettype wire

/* rtl/pma_tx_top.sv */
`default_nettype none

module pma_tx_top #(
  parameter int unsigned FIFO_DEPTH = pma_tx_pkg::DEF_FIFO_DEPTH
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  pma_tx_pkg::axil_req_t axil_req,
  output pma_tx_pkg::axil_rsp_t axil_rsp,
  input  logic                  word_valid,
  input  pma_tx_pkg::word_t     word_data,
  output logic                  word_ready,
  output pma_tx_pkg::line_out_t line_out
);

  import pma_tx_pkg::*;

  tx_ctrl_t tx_ctrl;
  word_t    fifo_data;
  logic     fifo_valid;
  logic     fifo_pop;
  logic     load;
  logic     ser_idle;
  logic     bit_tick;
  logic     word_done;

  pma_tx_csr u_csr (
    .clk       (clk),
    .arst_n    (arst_n),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .word_done (word_done),
    .tx_ctrl   (tx_ctrl)
  );

  pma_tx_rate_gen u_rate_gen (
    .clk      (clk),
    .arst_n   (arst_n),
    .div_code (tx_ctrl.div_code),
    .load     (load),
    .ser_idle (ser_idle),
    .bit_tick (bit_tick)
  );

  pma_tx_word_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_word_fifo (
    .clk        (clk),
    .arst_n     (arst_n),
    .word_valid (word_valid),
    .word_data  (word_data),
    .word_ready (word_ready),
    .fifo_valid (fifo_valid),
    .fifo_data  (fifo_data),
    .fifo_pop   (fifo_pop)
  );

  pma_tx_serializer u_serializer (
    .clk        (clk),
    .arst_n     (arst_n),
    .bit_tick   (bit_tick),
    .fifo_valid (fifo_valid),
    .fifo_data  (fifo_data),
    .fifo_pop   (fifo_pop),
    .tx_ctrl    (tx_ctrl),
    .load       (load),
    .ser_idle   (ser_idle),
    .word_done  (word_done),
    .line_out   (line_out)
  );

endmodule

`default_nettype wire

/* rtl/pma_tx_word_fifo.sv */
`default_nettype none

module pma_tx_word_fifo #(
  parameter int unsigned FIFO_DEPTH = pma_tx_pkg::DEF_FIFO_DEPTH
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              word_valid,
  input  pma_tx_pkg::word_t word_data,
  output logic              word_ready,
  output logic              fifo_valid,
  output pma_tx_pkg::word_t fifo_data,
  input  logic              fifo_pop
);

  import pma_tx_pkg::*;

  localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  word_t            mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign word_ready = (count_q != CNT_W'(FIFO_DEPTH));
  assign fifo_valid = (count_q != '0);
  assign fifo_data  = mem_q[rd_ptr_q];

  assign push = word_valid && word_ready;
  assign pop  = fifo_pop && fifo_valid;

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= word_data;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire
